// File: verilog/flag_rf_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag register file package
// widths, counts, entry types and request structs shared by the
// banked flag register file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package flag_rf_pkg;

  localparam int NUM_BANKS = 4;
  localparam int NUM_ROWS  = 16;
  localparam int NUM_WRITE = 3;
  localparam int GAZUMP_W  = NUM_WRITE + 1;   // write ports, allocate on top.

  localparam int DATA_W = 6;
  localparam int BANK_W = $clog2(NUM_BANKS);
  localparam int ROW_W  = $clog2(NUM_ROWS);
  localparam int ADDR_W = BANK_W + ROW_W;     // bank in the low bits.

  typedef logic [ADDR_W-1:0]   flag_addr_t;
  typedef logic [BANK_W-1:0]   bank_sel_t;
  typedef logic [ROW_W-1:0]    row_t;
  typedef logic [DATA_W-1:0]   flag_data_t;
  typedef logic [DATA_W:0]     flag_entry_t;  // pending bit is the msb.
  typedef logic [GAZUMP_W-1:0] gazump_t;

  typedef struct packed {
    logic       wen;
    flag_addr_t addr;
    flag_data_t data;
  } write_req_t;

  typedef struct packed {
    logic       en;
    flag_addr_t addr;
  } alloc_req_t;

  typedef struct packed {
    logic        wen;
    row_t        row;
    flag_entry_t entry;
  } bank_write_t;

  typedef enum logic [0:0] {
    st_sweep,
    st_run
  } sweep_state_t;

endpackage

// File: verilog/flag_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag bank
// 16 entry write-first storage with three write ports, one allocate
// port and two read ports on registered row addresses.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module flag_bank (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  flag_rf_pkg::bank_write_t [flag_rf_pkg::NUM_WRITE-1:0] wr,
  input  logic                                                  alloc_en,
  input  flag_rf_pkg::row_t                                     alloc_row,
  input  logic                                                  read_en,
  input  flag_rf_pkg::row_t                                     read_row,
  input  logic                                                  retire_en,
  input  flag_rf_pkg::row_t                                     retire_row,
  output flag_rf_pkg::flag_entry_t                              read_entry,
  output flag_rf_pkg::flag_entry_t                              retire_entry
);

  import flag_rf_pkg::*;

  flag_entry_t mem [NUM_ROWS];

  row_t read_row_q;
  row_t retire_row_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // later assignments win, so port order gives the priority.
  always_ff @(posedge clk)
  begin
    for (int p = 0; p < NUM_WRITE; p++)
    begin
      if (wr[p].wen)
      begin
        mem[wr[p].row] <= wr[p].entry;
      end
    end
    if (alloc_en)
    begin
      mem[alloc_row] <= '1;  // pending, value all ones.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read addresses
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_row_q   <= '0;
      retire_row_q <= '0;
    end
    else
    begin
      if (read_en)
      begin
        read_row_q <= read_row;
      end
      if (retire_en)
      begin
        retire_row_q <= retire_row;
      end
    end
  end

  assign read_entry   = mem[read_row_q];    // sees the write of the same edge.
  assign retire_entry = mem[retire_row_q];

endmodule

// File: verilog/flag_bank_array.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag bank array
// four peer banks selected by the low address bits, with the clearing
// sweep on write port 0 and registered bank select for both reads.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module flag_bank_array (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  flag_rf_pkg::write_req_t [flag_rf_pkg::NUM_WRITE-1:0] wr,
  input  flag_rf_pkg::alloc_req_t                              alloc,
  input  logic                                                 sweep_en,
  input  flag_rf_pkg::row_t                                    sweep_row,
  input  logic                                                 read_en,
  input  flag_rf_pkg::flag_addr_t                              read_addr,
  input  logic                                                 retire_en,
  input  flag_rf_pkg::flag_addr_t                              retire_addr,
  output flag_rf_pkg::flag_entry_t                             bank_read,
  output flag_rf_pkg::flag_data_t                              retire_data
);

  import flag_rf_pkg::*;

  bank_write_t [NUM_BANKS-1:0][NUM_WRITE-1:0] bank_wr;
  flag_entry_t [NUM_BANKS-1:0]                read_entry;
  flag_entry_t [NUM_BANKS-1:0]                retire_entry;

  bank_sel_t   read_bank;
  bank_sel_t   retire_bank;
  bank_sel_t   alloc_bank;
  bank_sel_t   read_bank_q;
  bank_sel_t   retire_bank_q;
  flag_entry_t retire_sel;

  assign read_bank   = read_addr[BANK_W-1:0];
  assign retire_bank = retire_addr[BANK_W-1:0];
  assign alloc_bank  = alloc.addr[BANK_W-1:0];

  // fan each write to the bank its low address bits select.
  always_comb
  begin
    for (int b = 0; b < NUM_BANKS; b++)
    begin
      for (int p = 0; p < NUM_WRITE; p++)
      begin
        bank_wr[b][p].wen   = wr[p].wen && (wr[p].addr[BANK_W-1:0] == bank_sel_t'(b));
        bank_wr[b][p].row   = wr[p].addr[ADDR_W-1:BANK_W];
        bank_wr[b][p].entry = {1'b0, wr[p].data};  // a write clears pending.
      end
      if (sweep_en)
      begin
        bank_wr[b][0].wen   = 1'b1;  // sweep owns port 0 of every bank.
        bank_wr[b][0].row   = sweep_row;
        bank_wr[b][0].entry = '0;
      end
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    flag_bank i_bank (
      .clk          (clk),
      .rst          (rst),
      .wr           (bank_wr[b]),
      .alloc_en     (alloc.en && (alloc_bank == bank_sel_t'(b))),
      .alloc_row    (alloc.addr[ADDR_W-1:BANK_W]),
      .read_en      (read_en && (read_bank == bank_sel_t'(b))),
      .read_row     (read_addr[ADDR_W-1:BANK_W]),
      .retire_en    (retire_en && (retire_bank == bank_sel_t'(b))),
      .retire_row   (retire_addr[ADDR_W-1:BANK_W]),
      .read_entry   (read_entry[b]),
      .retire_entry (retire_entry[b])
    );
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      read_bank_q   <= '0;
      retire_bank_q <= '0;
    end
    else
    begin
      if (read_en)
      begin
        read_bank_q <= read_bank;
      end
      if (retire_en)
      begin
        retire_bank_q <= retire_bank;
      end
    end
  end

  assign bank_read   = read_entry[read_bank_q];
  assign retire_sel  = retire_entry[retire_bank_q];
  assign retire_data = retire_sel[DATA_W-1:0];  // pending bit not returned.

endmodule

// File: verilog/flag_init_sweep.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// post-reset clearing sweep
// walks every row once after reset, zeroing it in all banks through
// write port 0, then raises ready.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module flag_init_sweep (
  input  logic              clk,
  input  logic              rst,
  output logic              sweep_en,
  output flag_rf_pkg::row_t sweep_row,
  output logic              ready
);

  import flag_rf_pkg::*;

  localparam row_t LAST_ROW = row_t'(NUM_ROWS - 1);

  sweep_state_t state;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= st_sweep;
      sweep_row <= '0;
    end
    else
    begin
      case (state)
        st_sweep:
        begin
          sweep_row <= sweep_row + 1'b1;  // wraps to zero on the last row.
          if (sweep_row == LAST_ROW)
          begin
            state <= st_run;
          end
        end
        st_run:
        begin
          sweep_row <= '0;
        end
        default:
        begin
          state <= st_sweep;
        end
      endcase
    end
  end

  assign sweep_en = (state == st_sweep);
  assign ready    = (state == st_run);

endmodule

// File: verilog/flag_forward.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// write stage and zero-cycle forwarding
// delays all writes one cycle on their way to the banks and bypasses
// the staged requests onto the speculative read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module flag_forward (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  flag_rf_pkg::write_req_t [flag_rf_pkg::NUM_WRITE-1:0] wr_in,
  input  flag_rf_pkg::alloc_req_t                              alloc_in,
  input  logic                                                 read_en,
  input  flag_rf_pkg::flag_addr_t                              read_addr,
  input  flag_rf_pkg::flag_entry_t                             bank_read,
  output flag_rf_pkg::write_req_t [flag_rf_pkg::NUM_WRITE-1:0] wr_stage,
  output flag_rf_pkg::alloc_req_t                              alloc_stage,
  output flag_rf_pkg::flag_entry_t                             read_data,
  output flag_rf_pkg::gazump_t                                 read_gazump
);

  import flag_rf_pkg::*;

  flag_addr_t  read_addr_q;
  logic        read_valid_q;
  flag_entry_t fwd_entry;
  gazump_t     fwd_gazump;
  flag_entry_t hold_entry;
  gazump_t     hold_gazump;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write stage and read address
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int p = 0; p < NUM_WRITE; p++)
      begin
        wr_stage[p].wen <= 1'b0;
      end
      alloc_stage.en <= 1'b0;
      read_valid_q   <= 1'b0;
      read_addr_q    <= '0;
    end
    else
    begin
      wr_stage     <= wr_in;
      alloc_stage  <= alloc_in;
      read_valid_q <= read_en;
      if (read_en)
      begin
        read_addr_q <= read_addr;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bypass select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // staged requests land in the bank only at the end of this cycle.
  always_comb
  begin
    fwd_entry  = bank_read;
    fwd_gazump = '0;
    for (int p = 0; p < NUM_WRITE; p++)
    begin
      if (wr_stage[p].wen && (wr_stage[p].addr == read_addr_q))
      begin
        fwd_entry     = {1'b0, wr_stage[p].data};  // higher port overrides.
        fwd_gazump    = '0;
        fwd_gazump[p] = 1'b1;
      end
    end
    if (alloc_stage.en && (alloc_stage.addr == read_addr_q))
    begin
      fwd_entry             = '1;  // allocate beats every write.
      fwd_gazump            = '0;
      fwd_gazump[NUM_WRITE] = 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hold_entry  <= '0;
      hold_gazump <= '0;
    end
    else if (read_valid_q)
    begin
      hold_entry  <= fwd_entry;
      hold_gazump <= fwd_gazump;
    end
  end

  // live value in the cycle after a read, held copy afterwards.
  assign read_data   = read_valid_q ? fwd_entry : hold_entry;
  assign read_gazump = read_valid_q ? fwd_gazump : hold_gazump;

endmodule

// File: verilog/flag_regfile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// banked flag register file
// 64 entries of flags plus pending bit, three write ports, one
// allocate port, a forwarded speculative read and a retire read.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module flag_regfile (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  flag_rf_pkg::write_req_t [flag_rf_pkg::NUM_WRITE-1:0] wr,
  input  flag_rf_pkg::alloc_req_t                              alloc,
  input  logic                                                 read_en,
  input  flag_rf_pkg::flag_addr_t                              read_addr,
  input  logic                                                 retire_en,
  input  flag_rf_pkg::flag_addr_t                              retire_addr,
  output flag_rf_pkg::flag_entry_t                             read_data,
  output flag_rf_pkg::gazump_t                                 read_gazump,
  output flag_rf_pkg::flag_data_t                              retire_data,
  output logic                                                 ready
);

  import flag_rf_pkg::*;

  write_req_t [NUM_WRITE-1:0] wr_stage;
  alloc_req_t                 alloc_stage;
  flag_entry_t                bank_read;
  logic                       sweep_en;
  row_t                       sweep_row;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write stage and bypass
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  flag_forward i_forward (
    .clk         (clk),
    .rst         (rst),
    .wr_in       (wr),
    .alloc_in    (alloc),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .bank_read   (bank_read),
    .wr_stage    (wr_stage),
    .alloc_stage (alloc_stage),
    .read_data   (read_data),
    .read_gazump (read_gazump)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // clearing sweep
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  flag_init_sweep i_sweep (
    .clk       (clk),
    .rst       (rst),
    .sweep_en  (sweep_en),
    .sweep_row (sweep_row),
    .ready     (ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  flag_bank_array i_banks (
    .clk         (clk),
    .rst         (rst),
    .wr          (wr_stage),
    .alloc       (alloc_stage),
    .sweep_en    (sweep_en),
    .sweep_row   (sweep_row),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .retire_en   (retire_en),
    .retire_addr (retire_addr),
    .bank_read   (bank_read),
    .retire_data (retire_data)
  );

endmodule

// File: tb/flag_regfile_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag register file checker
// keeps a 64 entry model and compares the read, gazump and retire
// results one cycle after each request.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module flag_regfile_checker (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  flag_rf_pkg::write_req_t [flag_rf_pkg::NUM_WRITE-1:0] wr,
  input  flag_rf_pkg::alloc_req_t                              alloc,
  input  logic                                                 read_en,
  input  flag_rf_pkg::flag_addr_t                              read_addr,
  input  logic                                                 retire_en,
  input  flag_rf_pkg::flag_addr_t                              retire_addr,
  input  flag_rf_pkg::flag_entry_t                             read_data,
  input  flag_rf_pkg::gazump_t                                 read_gazump,
  input  flag_rf_pkg::flag_data_t                              retire_data,
  input  logic                                                 ready,
  output int                                                   check_count,
  output int                                                   error_count
);

  import flag_rf_pkg::*;

  flag_entry_t model [NUM_BANKS*NUM_ROWS];
  flag_entry_t exp_read;
  gazump_t     exp_gazump;
  flag_data_t  exp_retire;
  logic        retire_due;
  logic        ready_seen;

  initial
  begin
    for (int i = 0; i < NUM_BANKS*NUM_ROWS; i++)
    begin
      model[i] = '0;  // the sweep leaves every entry zero.
    end
    check_count = 0;
    error_count = 0;
    exp_read    = '0;
    exp_gazump  = '0;
    exp_retire  = '0;
    retire_due  = 1'b0;
    ready_seen  = 1'b0;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference functions
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // the entry as if this cycle's requests had already landed.
  function automatic void expect_read(input flag_addr_t addr, output flag_entry_t entry,
                                      output gazump_t gz);
    entry = model[addr];
    gz    = '0;
    if (alloc.en && (alloc.addr == addr))
    begin
      entry         = '1;
      gz[NUM_WRITE] = 1'b1;
    end
    else
    begin
      for (int p = NUM_WRITE - 1; p >= 0; p--)
      begin
        if ((gz == '0) && wr[p].wen && (wr[p].addr == addr))
        begin
          entry = {1'b0, wr[p].data};  // highest matching port only.
          gz[p] = 1'b1;
        end
      end
    end
  endfunction

  function automatic flag_data_t expect_retire(input flag_addr_t addr);
    return model[addr][DATA_W-1:0];  // no forwarding.
  endfunction

  task automatic apply_requests();
    for (int p = 0; p < NUM_WRITE; p++)
    begin
      if (wr[p].wen)
      begin
        model[wr[p].addr] = {1'b0, wr[p].data};
      end
    end
    if (alloc.en)
    begin
      model[alloc.addr] = '1;
    end
  endtask

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] want);
    check_count++;
    if (got !== want)
    begin
      error_count++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, name, got, want);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // comparing process
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(negedge clk)
  begin
    if (rst)
    begin
      retire_due = 1'b0;
      ready_seen = 1'b0;
    end
    else
    begin
      if (ready_seen)
      begin
        compare("ready", 16'(ready), 16'h1);  // stays high once the sweep is done.
      end
      if (ready)
      begin
        ready_seen = 1'b1;
        compare("read_data", 16'(read_data), 16'(exp_read));  // held between reads.
        compare("read_gazump", 16'(read_gazump), 16'(exp_gazump));
        if (retire_due)
        begin
          compare("retire_data", 16'(retire_data), 16'(exp_retire));
        end
        retire_due = retire_en;
        if (retire_en)
        begin
          exp_retire = expect_retire(retire_addr);
        end
        if (read_en)
        begin
          expect_read(read_addr, exp_read, exp_gazump);
        end
        apply_requests();
      end
    end
  end

endmodule

// File: tb/flag_regfile_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// flag register file testbench
// clock, reset, directed and random traffic for the banked flag file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module flag_regfile_tb;

  import flag_rf_pkg::*;

  localparam int unsigned SEED          = 32'hb96a_c67d;
  localparam int          RESET_CYCLES  = 4;
  localparam int          READY_TIMEOUT = 100;
  localparam int          RANDOM_CYCLES = 4000;
  localparam int          POOL_SIZE     = 6;  // small, so addresses collide often.

  logic                       clk;
  logic                       rst;
  write_req_t [NUM_WRITE-1:0] wr;
  alloc_req_t                 alloc;
  logic                       read_en;
  flag_addr_t                 read_addr;
  logic                       retire_en;
  flag_addr_t                 retire_addr;
  flag_entry_t                read_data;
  gazump_t                    read_gazump;
  flag_data_t                 retire_data;
  logic                       ready;
  int                         check_count;
  int                         error_count;
  flag_addr_t                 pool [POOL_SIZE];

  flag_regfile i_dut (
    .clk         (clk),
    .rst         (rst),
    .wr          (wr),
    .alloc       (alloc),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .retire_en   (retire_en),
    .retire_addr (retire_addr),
    .read_data   (read_data),
    .read_gazump (read_gazump),
    .retire_data (retire_data),
    .ready       (ready)
  );

  flag_regfile_checker i_checker (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // one request cycle, driven on the rising edge.
  task automatic drive(input write_req_t [NUM_WRITE-1:0] w, input alloc_req_t a,
                       input logic re, input flag_addr_t ra,
                       input logic te, input flag_addr_t ta);
    @(posedge clk);
    wr          <= w;
    alloc       <= a;
    read_en     <= re;
    read_addr   <= ra;
    retire_en   <= te;
    retire_addr <= ta;
  endtask

  function automatic write_req_t write_to(input flag_addr_t addr, input flag_data_t data);
    return '{wen: 1'b1, addr: addr, data: data};
  endfunction

  task automatic drive_random();
    write_req_t [NUM_WRITE-1:0] w;
    alloc_req_t                 a;
    for (int p = 0; p < NUM_WRITE; p++)
    begin
      w[p]     = write_to(pool[$urandom_range(POOL_SIZE-1)], flag_data_t'($urandom));
      w[p].wen = ($urandom_range(1) == 1);
    end
    a.en   = ($urandom_range(3) == 0);
    a.addr = pool[$urandom_range(POOL_SIZE-1)];
    drive(w, a, $urandom_range(3) != 0, pool[$urandom_range(POOL_SIZE-1)],
          $urandom_range(1) == 1, pool[$urandom_range(POOL_SIZE-1)]);
  endtask

  initial
  begin
    write_req_t [NUM_WRITE-1:0] w;
    write_req_t [NUM_WRITE-1:0] none;
    alloc_req_t                 no_alloc;
    int                         waited;
    rst         = 1'b1;
    wr          = '0;
    alloc       = '0;
    read_en     = 1'b0;
    read_addr   = '0;
    retire_en   = 1'b0;
    retire_addr = '0;
    none        = '0;
    no_alloc    = '0;
    void'($urandom(SEED));
    for (int i = 0; i < POOL_SIZE; i++)
    begin
      pool[i] = flag_addr_t'($urandom);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    waited = 0;
    while (!ready && (waited < READY_TIMEOUT))
    begin
      @(negedge clk);
      waited++;
    end
    if (!ready)
    begin
      $display("timeout: ready still low %0d cycles after reset", READY_TIMEOUT);
      $display("Something failed");
      $finish;
    end
    else
    begin
      for (int i = 0; i < 4; i++)
      begin
        drive(none, no_alloc, 1'b1, pool[i], 1'b1, pool[i]);  // swept entries read zero.
      end
      w    = none;
      w[0] = write_to(6'h05, 6'h2a);
      drive(w, no_alloc, 1'b0, '0, 1'b0, '0);
      drive(none, no_alloc, 1'b1, 6'h05, 1'b1, 6'h05);  // from the bank.
      w    = none;
      w[1] = write_to(6'h12, 6'h15);
      drive(w, no_alloc, 1'b1, 6'h12, 1'b0, '0);        // forwarded from port 1.
      for (int p = 0; p < NUM_WRITE; p++)
      begin
        w[p] = write_to(6'h23, flag_data_t'(p + 1));
      end
      drive(w, alloc_req_t'{en: 1'b1, addr: 6'h23}, 1'b1, 6'h23, 1'b0, '0);
      drive(none, no_alloc, 1'b1, 6'h23, 1'b1, 6'h23);
      for (int p = 0; p < NUM_WRITE; p++)
      begin
        w[p] = write_to(6'h31, flag_data_t'(6'h10 + p));
      end
      drive(w, no_alloc, 1'b1, 6'h31, 1'b0, '0);        // top port wins.
      w    = none;
      w[2] = write_to(6'h05, 6'h07);
      drive(w, no_alloc, 1'b0, '0, 1'b1, 6'h05);        // retire sees the old value.
      drive(none, no_alloc, 1'b0, '0, 1'b1, 6'h05);
      repeat (RANDOM_CYCLES) drive_random();
      drive(none, no_alloc, 1'b0, '0, 1'b0, '0);
      repeat (2) @(negedge clk);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
      begin
        $display("Everything OK");
      end
      else
      begin
        $display("Something failed");
      end
      $finish;
    end
  end

endmodule

// File: build.f
verilog/flag_rf_pkg.sv
verilog/flag_bank.sv
verilog/flag_bank_array.sv
verilog/flag_init_sweep.sv
verilog/flag_forward.sv
verilog/flag_regfile.sv
tb/flag_regfile_checker.sv
tb/flag_regfile_tb.sv

// File: Bender.yml
package:
  name: flag_regfile

sources:
  - verilog/flag_rf_pkg.sv
  - verilog/flag_bank.sv
  - verilog/flag_bank_array.sv
  - verilog/flag_init_sweep.sv
  - verilog/flag_forward.sv
  - verilog/flag_regfile.sv
  - target: test
    files:
      - tb/flag_regfile_checker.sv
      - tb/flag_regfile_tb.sv
